/* sim.f */
+incdir+include
logic/plot_pkg.sv
logic/history_plotter.sv
logic/burst_arbiter.sv
logic/lcd_scanout.sv
logic/plot_display_top.sv
tests/burst_mem_model.sv
tests/plot_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the plot display regression with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module plot_display_tb \
    -f sim.f -Mdir obj_dir -o plot_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/plot_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

/* tests/plot_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rgb565_colors.svh"

module plot_display_tb
    import plot_pkg::*;
();

    localparam int SCREEN_W   = 32;
    localparam int SCREEN_H   = 24;
    localparam int PLOT_X0    = 4;
    localparam int PLOT_Y0    = 2;
    localparam int BAR_LEN    = 16;
    localparam int HIST_DEPTH = 8;
    localparam int FB_WORDS   = SCREEN_W * SCREEN_H;  // Ring starts here.
    localparam int CLK_NS     = 40;
    localparam int N_FRAMES   = 20;
    localparam int ACCESS_CYC = 24;  // One burst plus worst arbitration wait.
    localparam int FRAME_CYC  = (1 + HIST_DEPTH * (BAR_LEN / 4 + 2)) * ACCESS_CYC;
    localparam int LIMIT_CYC  = (N_FRAMES + 4) * FRAME_CYC;  // Two start-ups and a pause.

    // Stimulus of one frame.
    typedef struct packed {
        sample_t    smp;
        lcd_count_t cnt;
        gain_code_t gain;
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       en;
    logic       sample_strobe;
    sample_t    sample;
    lcd_count_t lcd_count;
    gain_code_t gain_code;
    mem_cmd_t   mem_cmd;
    logic       mem_ack;
    burst_t     mem_rdata;
    pixel_t     pix;
    logic       pix_valid;
    logic       line_start;
    logic       frame_start;
    logic       frame_done;
    lcd_count_t max_count;
    lcd_count_t min_count;

    entry_t      pending [$];          // Strobed but not yet checked.
    sample_t     ref_smp [HIST_DEPTH];
    lcd_count_t  ref_cnt [HIST_DEPTH];
    int          ref_ptr;
    lcd_count_t  ref_max;
    lcd_count_t  ref_min;
    logic [15:0] lfsr = 16'd39;
    int          errors = 0;
    int          checks = 0;
    int          scan_addr;
    logic        scan_sync;            // First frame_start seen.

    plot_display_top #(
        .SCREEN_W   (SCREEN_W),
        .SCREEN_H   (SCREEN_H),
        .PLOT_X0    (PLOT_X0),
        .PLOT_Y0    (PLOT_Y0),
        .BAR_LEN    (BAR_LEN),
        .HIST_DEPTH (HIST_DEPTH)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .lcd_count     (lcd_count),
        .gain_code     (gain_code),
        .mem_cmd       (mem_cmd),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .pix           (pix),
        .pix_valid     (pix_valid),
        .line_start    (line_start),
        .frame_start   (frame_start),
        .frame_done    (frame_done),
        .max_count     (max_count),
        .min_count     (min_count)
    );

    burst_mem_model #(.DEPTH(FB_WORDS + 4 * HIST_DEPTH)) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [23:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[22:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);  // One step per bit.
        end
    endtask

    // Divider shifts by code minus one for codes 2 to 4.
    function automatic int bar_end_ref(input sample_t s, input gain_code_t g);
        int shift;
        int len;
        shift = (g >= 8'd2 && g <= 8'd4) ? int'(g) - 1 : 0;
        len   = int'(s) >> shift;
        if (len > BAR_LEN) len = BAR_LEN;
        return PLOT_X0 + len;
    endfunction

    // Colour of every word in the burst at column c.
    function automatic pixel_t color_ref(input int c, input int bar_end);
        return (c + 3 <= bar_end) ? `BAR_COLOR : `BG_COLOR;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Scroll the reference ring, then compare ring, rows and extremes.
    task automatic check_frame(input entry_t e);
        int store;
        int slot;
        int a;
        int bar_end;
        ref_ptr = (ref_ptr + 1) % HIST_DEPTH;
        store   = (ref_ptr + HIST_DEPTH - 1) % HIST_DEPTH;
        ref_smp[store] = e.smp;
        ref_cnt[store] = e.cnt;
        for (int k = 0; k < HIST_DEPTH; k++) begin
            a = FB_WORDS + 4 * k;
            check_value($sformatf("ring[%0d].w0", k), ref_smp[k], u_mem.mem[a]);
            check_value($sformatf("ring[%0d].w1", k), ref_cnt[k][23:16], u_mem.mem[a + 1]);
            check_value($sformatf("ring[%0d].w2", k), ref_cnt[k][15:8], u_mem.mem[a + 2]);
            check_value($sformatf("ring[%0d].w3", k), ref_cnt[k][7:0], u_mem.mem[a + 3]);
            if (ref_cnt[k] > ref_max) ref_max = ref_cnt[k];  // Every slot is read.
            if (ref_cnt[k] < ref_min) ref_min = ref_cnt[k];
        end
        for (int r = 0; r < HIST_DEPTH; r++) begin
            slot    = (ref_ptr + r) % HIST_DEPTH;
            bar_end = bar_end_ref(ref_smp[slot], e.gain);
            a       = (PLOT_Y0 + r) * SCREEN_W;
            for (int c = PLOT_X0; c < PLOT_X0 + BAR_LEN + 4; c++) begin
                check_value($sformatf("gram row %0d col %0d", r, c),
                            color_ref(c - c % 4, bar_end), u_mem.mem[a + c]);
            end
        end
        check_value("max_count", ref_max, max_count);
        check_value("min_count", ref_min, min_count);
    endtask

    task automatic apply_sample();
        logic [23:0] bits;
        entry_t      e;
        draw_bits(6, bits);  // Small counts, so the clamp is both hit and missed.
        e.smp = sample_t'(bits);
        draw_bits(24, bits);
        e.cnt = bits;
        draw_bits(2, bits);
        e.gain = gain_code_t'(bits) + 8'd1;
        sample        = e.smp;
        lcd_count     = e.cnt;
        gain_code     = e.gain;
        sample_strobe = 1'b1;
        pending.push_back(e);
        @(negedge clk);
        sample_strobe = 1'b0;
    endtask

    task automatic wait_frame();
        do begin
            @(negedge clk);
        end while (!frame_done);
    endtask

    // Drop en inside a frame, watch the port go quiet, then start again.
    task automatic restart_plotter();
        repeat (30) @(negedge clk);
        en = 1'b0;
        repeat (ACCESS_CYC) @(negedge clk);  // Pending ack drains.
        repeat (40) begin
            @(negedge clk);
            // Scan-out reads stay inside the frame buffer.
            if (mem_cmd.req && (mem_cmd.we || int'(mem_cmd.addr) >= FB_WORDS)) begin
                errors++;
                $display("Plotter request on the port while disabled at %0t", $time);
            end
        end
        en = 1'b1;
    endtask

    task automatic check_reset_state();
        check_value("mem_cmd.req", 1'b0, mem_cmd.req);
        check_value("frame_done", 1'b0, frame_done);
        check_value("pix_valid", 1'b0, pix_valid);
        check_value("line_start", 1'b0, line_start);
        check_value("frame_start", 1'b0, frame_start);
        check_value("max_count", 24'h000000, max_count);
        check_value("min_count", 24'hFFFFFF, min_count);
    endtask

    ////////////////////////////////////////
    initial begin
        rst_n         = 1'b0;
        en            = 1'b0;
        sample_strobe = 1'b0;
        sample        = '0;
        lcd_count     = '0;
        gain_code     = 8'd1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        apply_sample();  // Stored by the first frame.
        en = 1'b1;
        for (int f = 0; f < N_FRAMES; f++) begin
            wait_frame();
            apply_sample();
            if (f == N_FRAMES / 2) restart_plotter();
        end
        repeat (8) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Compare process sampling mid-cycle.
    initial begin
        ref_max   = '0;
        ref_min   = '1;
        ref_ptr   = 0;
        scan_addr = 0;
        scan_sync = 1'b0;
        forever begin
            @(negedge clk);
            if (!en) begin
                ref_ptr = 0;  // Start-up clear follows.
                for (int k = 0; k < HIST_DEPTH; k++) begin
                    ref_smp[k] = '0;
                    ref_cnt[k] = '0;
                end
            end
            if (frame_done) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("Frame finished with no sample strobed for it at %0t", $time);
                end else begin
                    check_frame(pending.pop_front());
                end
            end
            if (pix_valid) begin
                if (scan_sync) check_value("frame_start", scan_addr == 0, frame_start);
                if (frame_start) begin
                    scan_sync = 1'b1;
                    scan_addr = 0;
                end
                if (scan_sync) begin
                    check_value($sformatf("pix at %0d", scan_addr), u_mem.mem[scan_addr], pix);
                    check_value("line_start", scan_addr % SCREEN_W == 0, line_start);
                    scan_addr = (scan_addr + 1) % FB_WORDS;
                end
            end else if (line_start || frame_start) begin
                errors++;
                $display("Line or frame marker without a pixel at %0t", $time);
            end
        end
    end

    // Watchdog.
    initial begin
        #(LIMIT_CYC * CLK_NS);
        $display("Timeout after %0d cycles, frames stopped completing", LIMIT_CYC);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/burst_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_mem_model
    import plot_pkg::*;
#(
    parameter int DEPTH     = 1024,
    parameter int ACK_DELAY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_cmd_t mem_cmd,
    output logic     mem_ack,
    output burst_t   mem_rdata
);

    pixel_t mem [0:DEPTH-1];  // Word array, read by the bench by name.
    logic   busy;             // Request accepted, ack not yet given.
    int     wait_cnt;
    int     base;

    // Power-up contents, a different word for every address.
    function automatic pixel_t fill_word(input int a);
        return pixel_t'(a * 40503) ^ pixel_t'(a >>> 16) ^ 16'h5A3C;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
            base      <= 0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            mem_ack <= 1'b0;  // One-cycle pulse.
            if (busy) begin
                if (wait_cnt == 0) begin
                    // Requester still holds its fields here.
                    mem_ack <= 1'b1;
                    busy    <= 1'b0;
                    if (mem_cmd.we) begin
                        mem[base]     <= mem_cmd.wdata.w0;
                        mem[base + 1] <= mem_cmd.wdata.w1;
                        mem[base + 2] <= mem_cmd.wdata.w2;
                        mem[base + 3] <= mem_cmd.wdata.w3;
                    end else begin
                        mem_rdata <= '{w0: mem[base], w1: mem[base + 1],
                                       w2: mem[base + 2], w3: mem[base + 3]};
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_cmd.req && !mem_ack) begin
                // Not on the ack cycle, the old request is still up.
                busy     <= 1'b1;
                base     <= int'(mem_cmd.addr);
                wait_cnt <= ACK_DELAY - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/plot_display_top.sv */
`timescale 1ns/10ps
`default_nettype none

module plot_display_top
    import plot_pkg::*;
#(
    parameter int SCREEN_W   = 32,
    parameter int SCREEN_H   = 24,
    parameter int PLOT_X0    = 4,   // Multiple of 4.
    parameter int PLOT_Y0    = 2,
    parameter int BAR_LEN    = 16,  // Multiple of 4.
    parameter int HIST_DEPTH = 8    // One slot per plot row.
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       sample_strobe,
    input  sample_t    sample,
    input  lcd_count_t lcd_count,
    input  gain_code_t gain_code,
    output mem_cmd_t   mem_cmd,
    input  logic       mem_ack,
    input  burst_t     mem_rdata,
    output pixel_t     pix,
    output logic       pix_valid,
    output logic       line_start,
    output logic       frame_start,
    output logic       frame_done,
    output lcd_count_t max_count,
    output lcd_count_t min_count
);

    mem_cmd_t plot_rd_cmd;
    mem_cmd_t plot_wr_cmd;
    mem_cmd_t scan_rd_cmd;
    logic     plot_rd_done;
    logic     plot_wr_done;
    logic     scan_rd_done;
    burst_t   arb_rdata;   // Shared read data to all clients.

    ////////////////////////////////////////
    history_plotter #(
        .SCREEN_W   (SCREEN_W),
        .SCREEN_H   (SCREEN_H),
        .PLOT_X0    (PLOT_X0),
        .PLOT_Y0    (PLOT_Y0),
        .BAR_LEN    (BAR_LEN),
        .HIST_DEPTH (HIST_DEPTH)
    ) u_plotter (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .lcd_count     (lcd_count),
        .gain_code     (gain_code),
        .rd_cmd        (plot_rd_cmd),
        .rd_done       (plot_rd_done),
        .rd_data       (arb_rdata),
        .wr_cmd        (plot_wr_cmd),
        .wr_done       (plot_wr_done),
        .frame_done    (frame_done),
        .max_count     (max_count),
        .min_count     (min_count)
    );

    lcd_scanout #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_scanout (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_cmd      (scan_rd_cmd),
        .rd_done     (scan_rd_done),
        .rd_data     (arb_rdata),
        .pix         (pix),
        .pix_valid   (pix_valid),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    ////////////////////////////////////////
    burst_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_a     (plot_rd_cmd),
        .cmd_b     (plot_wr_cmd),
        .cmd_c     (scan_rd_cmd),
        .done_a    (plot_rd_done),
        .done_b    (plot_wr_done),
        .done_c    (scan_rd_done),
        .rdata     (arb_rdata),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* logic/lcd_scanout.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rgb565_colors.svh"

module lcd_scanout
    import plot_pkg::*;
#(
    parameter int SCREEN_W = 32,
    parameter int SCREEN_H = 24
) (
    input  logic     clk,
    input  logic     rst_n,
    output mem_cmd_t rd_cmd,
    input  logic     rd_done,
    input  burst_t   rd_data,
    output pixel_t   pix,
    output logic     pix_valid,
    output logic     line_start,
    output logic     frame_start
);

    localparam mem_addr_t LAST_BURST = mem_addr_t'(SCREEN_W * SCREEN_H - 4);
    localparam mem_addr_t LINE_LAST  = mem_addr_t'(SCREEN_W - 4);

    mem_addr_t  addr_q;        // Next burst to fetch.
    mem_addr_t  col_q;         // Its column in the row.
    pixel_t     shift_q [0:2]; // Words 1 to 3 still to go out.
    logic [1:0] left_q;

    always_ff @(posedge clk) begin
        if (rd_done) begin
            shift_q[0] <= rd_data.w1;
            shift_q[1] <= rd_data.w2;
            shift_q[2] <= rd_data.w3;
        end else if (left_q != '0) begin
            shift_q[0] <= shift_q[1];
            shift_q[1] <= shift_q[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cmd      <= '0;
            addr_q      <= '0;
            col_q       <= '0;
            left_q      <= '0;
            pix         <= `IDLE_COLOR;
            pix_valid   <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            line_start  <= 1'b0;
            frame_start <= 1'b0;
            if (rd_done) begin
                // Word 0 goes out right away.
                rd_cmd.req  <= 1'b0;
                pix         <= rd_data.w0;
                pix_valid   <= 1'b1;
                line_start  <= (col_q == '0);
                frame_start <= (addr_q == '0);
                left_q      <= 2'd3;
                addr_q      <= (addr_q == LAST_BURST) ? '0 : addr_q + mem_addr_t'(4);
                col_q       <= (col_q == LINE_LAST) ? '0 : col_q + mem_addr_t'(4);
            end else if (left_q != '0) begin
                pix    <= shift_q[0];
                left_q <= left_q - 1'b1;
            end else begin
                pix       <= `IDLE_COLOR;
                pix_valid <= 1'b0;
                // Fetch only once the last burst is out.
                if (!rd_cmd.req) rd_cmd <= '{req: 1'b1, we: 1'b0, addr: addr_q, wdata: '0};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/burst_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_arbiter
    import plot_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_cmd_t cmd_a,     // Drawer read.
    input  mem_cmd_t cmd_b,     // Drawer write.
    input  mem_cmd_t cmd_c,     // Scan-out read.
    output logic     done_a,
    output logic     done_b,
    output logic     done_c,
    output burst_t   rdata,
    output mem_cmd_t mem_cmd,
    input  logic     mem_ack,
    input  burst_t   mem_rdata
);

    logic [2:0] req_vec;
    logic [2:0] pick;
    logic [2:0] grant;   // One-hot, zero when the port is free.
    logic [1:0] last;    // Client served last.

    assign req_vec = {cmd_c.req, cmd_b.req, cmd_a.req};

    // Search starts one past the last winner.
    always_comb begin
        int k;
        pick = '0;
        for (int i = 1; i <= 3; i++) begin
            k = (int'(last) + i) % 3;
            if (pick == '0 && req_vec[k]) pick[k] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
            last  <= 2'd2;  // Client a first.
        end else if (grant == '0) begin
            if (pick != '0) begin
                grant <= pick;
                last  <= pick[0] ? 2'd0 : (pick[1] ? 2'd1 : 2'd2);
            end
        end else if (mem_ack) begin
            grant <= '0;  // Free again next cycle.
        end
    end

    // Port mux.
    always_comb begin
        case (grant)
            3'b001:  mem_cmd = cmd_a;
            3'b010:  mem_cmd = cmd_b;
            3'b100:  mem_cmd = cmd_c;
            default: mem_cmd = '0;
        endcase
    end

    assign done_a = mem_ack & grant[0];
    assign done_b = mem_ack & grant[1];
    assign done_c = mem_ack & grant[2];
    assign rdata  = mem_rdata;  // Only the granted client takes it.

    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({done_c, done_b, done_a}));
    // Granted client keeps its request steady until the ack.
    a_port_hold: assert property (@(posedge clk) disable iff (!rst_n)
        grant != '0 && !mem_ack |=> mem_cmd.req && $stable(mem_cmd));

endmodule

`default_nettype wire

/* logic/history_plotter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rgb565_colors.svh"

module history_plotter
    import plot_pkg::*;
#(
    parameter int SCREEN_W   = 32,
    parameter int SCREEN_H   = 24,
    parameter int PLOT_X0    = 4,
    parameter int PLOT_Y0    = 2,
    parameter int BAR_LEN    = 16,
    parameter int HIST_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       sample_strobe,
    input  sample_t    sample,
    input  lcd_count_t lcd_count,
    input  gain_code_t gain_code,
    output mem_cmd_t   rd_cmd,
    input  logic       rd_done,
    input  burst_t     rd_data,
    output mem_cmd_t   wr_cmd,
    input  logic       wr_done,
    output logic       frame_done,
    output lcd_count_t max_count,
    output lcd_count_t min_count
);

    localparam int SLOT_W = $clog2(HIST_DEPTH);

    // History ring sits right after the frame buffer.
    localparam mem_addr_t RING_BASE = mem_addr_t'(SCREEN_W * SCREEN_H);
    localparam mem_addr_t ROW0_BASE = mem_addr_t'(PLOT_Y0 * SCREEN_W);
    localparam mem_addr_t COL_FIRST = mem_addr_t'(PLOT_X0);
    localparam mem_addr_t COL_LAST  = mem_addr_t'(PLOT_X0 + BAR_LEN);  // Last burst column.
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(HIST_DEPTH - 1);

    plot_state_e       state;
    logic [SLOT_W-1:0] rd_ptr;     // Oldest slot, shown on row 0.
    logic [SLOT_W-1:0] slot;       // Slot being cleared or read.
    logic [SLOT_W-1:0] row;        // Plot row index.
    logic [SLOT_W-1:0] store_slot;
    mem_addr_t         row_base;   // GRAM address of column 0 in this row.
    mem_addr_t         col;
    mem_addr_t         bar_end;
    mem_addr_t         rd_bar_end;
    sample_t           scaled;
    lcd_count_t        rd_count;
    sample_t           sample_q;
    lcd_count_t        count_q;

    function automatic logic [SLOT_W-1:0] next_slot(input logic [SLOT_W-1:0] s);
        return (s == SLOT_LAST) ? '0 : s + 1'b1;
    endfunction

    function automatic mem_addr_t slot_addr(input logic [SLOT_W-1:0] s);
        return RING_BASE + (mem_addr_t'(s) << 2);  // Four words per slot.
    endfunction

    function automatic burst_t fill(input pixel_t c);
        return '{w0: c, w1: c, w2: c, w3: c};
    endfunction

    function automatic mem_cmd_t wr_req(input mem_addr_t a, input burst_t d);
        return '{req: 1'b1, we: 1'b1, addr: a, wdata: d};
    endfunction

    // Latest sample, written at the next store.
    always_ff @(posedge clk) begin
        if (sample_strobe) begin
            sample_q <= sample;
            count_q  <= lcd_count;
        end
    end

    // Slot just behind the read pointer gets the new sample.
    assign store_slot = (slot == '0) ? SLOT_LAST : slot - 1'b1;

    // Gain divider.
    always_comb begin
        case (gain_code)
            8'd2:    scaled = rd_data.w0 >> 1;
            8'd3:    scaled = rd_data.w0 >> 2;
            8'd4:    scaled = rd_data.w0 >> 3;
            default: scaled = rd_data.w0;
        endcase
    end

    // Clamp to bar length.
    assign rd_bar_end = (scaled >= BAR_LEN) ? COL_LAST : COL_FIRST + mem_addr_t'(scaled);
    assign rd_count   = {rd_data.w1[7:0], rd_data.w2[7:0], rd_data.w3[7:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            rd_cmd     <= '0;
            wr_cmd     <= '0;
            rd_ptr     <= '0;
            slot       <= '0;
            row        <= '0;
            row_base   <= '0;
            col        <= '0;
            bar_end    <= '0;
            frame_done <= 1'b0;
            max_count  <= '0;
            min_count  <= '1;
        end else begin
            frame_done <= 1'b0;
            // A request always runs to its done, even after en drops.
            if (rd_done) rd_cmd.req <= 1'b0;
            if (wr_done) wr_cmd.req <= 1'b0;
            if (!en) begin
                state <= ST_IDLE;
            end else begin
                case (state)
                    ST_IDLE: begin
                        rd_ptr <= '0;
                        slot   <= '0;
                        if (!rd_cmd.req && !wr_cmd.req) state <= ST_RING_WR;  // Port clear.
                    end
                    ////////////////////////////////////////
                    ST_RING_WR: begin
                        if (wr_done) state <= ST_RING_STEP;
                        else if (!wr_cmd.req) wr_cmd <= wr_req(slot_addr(slot), '0);
                    end
                    ST_RING_STEP: begin
                        if (slot == SLOT_LAST) begin
                            row      <= '0;
                            row_base <= ROW0_BASE;
                            col      <= COL_FIRST;
                            state    <= ST_AREA_WR;
                        end else begin
                            slot  <= slot + 1'b1;
                            state <= ST_RING_WR;
                        end
                    end
                    ST_AREA_WR: begin
                        if (wr_done) state <= ST_AREA_STEP;
                        else if (!wr_cmd.req) wr_cmd <= wr_req(row_base + col, fill(`BG_COLOR));
                    end
                    ST_AREA_STEP: begin
                        state <= ST_AREA_WR;
                        if (col != COL_LAST) begin
                            col <= col + mem_addr_t'(4);
                        end else begin
                            col <= COL_FIRST;
                            if (row == SLOT_LAST) begin
                                state <= ST_FRAME_SETUP;
                            end else begin
                                row      <= row + 1'b1;
                                row_base <= row_base + mem_addr_t'(SCREEN_W);
                            end
                        end
                    end
                    ////////////////////////////////////////
                    ST_FRAME_SETUP: begin
                        rd_ptr   <= next_slot(rd_ptr);  // Scroll by one.
                        slot     <= next_slot(rd_ptr);
                        row      <= '0;
                        row_base <= ROW0_BASE;
                        col      <= COL_FIRST;
                        state    <= ST_STORE_WR;
                    end
                    ST_STORE_WR: begin
                        if (wr_done) begin
                            state <= ST_SLOT_RD;
                        end else if (!wr_cmd.req) begin
                            wr_cmd <= wr_req(slot_addr(store_slot),
                                             '{w0: sample_q,
                                               w1: {8'h00, count_q[23:16]},
                                               w2: {8'h00, count_q[15:8]},
                                               w3: {8'h00, count_q[7:0]}});
                        end
                    end
                    ST_SLOT_RD: begin
                        if (rd_done) begin
                            bar_end <= rd_bar_end;
                            if (rd_count > max_count) max_count <= rd_count;
                            if (rd_count < min_count) min_count <= rd_count;
                            state <= ST_BURST_WR;
                        end else if (!rd_cmd.req) begin
                            rd_cmd <= '{req: 1'b1, we: 1'b0, addr: slot_addr(slot), wdata: '0};
                        end
                    end
                    ST_BURST_WR: begin
                        if (wr_done) begin
                            state <= ST_BURST_STEP;
                        end else if (!wr_cmd.req) begin
                            // Whole burst inside the bar or none of it.
                            wr_cmd <= wr_req(row_base + col,
                                             (col + mem_addr_t'(3) <= bar_end) ?
                                             fill(`BAR_COLOR) : fill(`BG_COLOR));
                        end
                    end
                    ST_BURST_STEP: begin
                        if (col == COL_LAST) begin
                            col   <= COL_FIRST;
                            state <= ST_ROW_STEP;
                        end else begin
                            col   <= col + mem_addr_t'(4);
                            state <= ST_BURST_WR;
                        end
                    end
                    ST_ROW_STEP: begin
                        if (row == SLOT_LAST) begin
                            state <= ST_FRAME_END;
                        end else begin
                            row      <= row + 1'b1;
                            row_base <= row_base + mem_addr_t'(SCREEN_W);
                            slot     <= next_slot(slot);  // Ring order.
                            state    <= ST_SLOT_RD;
                        end
                    end
                    ST_FRAME_END: begin
                        frame_done <= 1'b1;
                        state      <= ST_FRAME_SETUP;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // One port client at a time toward the arbiter.
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_cmd.req && wr_cmd.req));
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd.req && !rd_done |=> rd_cmd.req);
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cmd.req && !wr_done |=> wr_cmd.req);

endmodule

`default_nettype wire

/* logic/plot_pkg.sv */
`default_nettype none

package plot_pkg;

    // SDRAM word address made of bank, row and column.
    typedef logic [23:0] mem_addr_t;
    typedef logic [15:0] pixel_t;      // One RGB565 word.
    typedef logic [15:0] sample_t;     // Raw pulse count.
    typedef logic [23:0] lcd_count_t;  // Display count, three bytes in memory.
    typedef logic [7:0]  gain_code_t;  // Divider selector.

    // Four words move per SDRAM access.
    typedef struct packed {
        pixel_t w0;
        pixel_t w1;
        pixel_t w2;
        pixel_t w3;
    } burst_t;

    // Request side of one burst port.
    typedef struct packed {
        logic      req;
        logic      we;    // High for a write.
        mem_addr_t addr;
        burst_t    wdata;
    } mem_cmd_t;

    // Drawer sequence.
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RING_WR,
        ST_RING_STEP,
        ST_AREA_WR,
        ST_AREA_STEP,
        ST_FRAME_SETUP,
        ST_STORE_WR,
        ST_SLOT_RD,
        ST_BURST_WR,
        ST_BURST_STEP,
        ST_ROW_STEP,
        ST_FRAME_END
    } plot_state_e;

endpackage

`default_nettype wire

/* include/rgb565_colors.svh */
`ifndef RGB565_COLORS_SVH
`define RGB565_COLORS_SVH

// Plot background, black.
`define BG_COLOR   16'h0000
// Bar fill, pink.
`define BAR_COLOR  16'hF81F
// Shown on the LCD bus between bursts.
`define IDLE_COLOR 16'h0000

`endif
